// File: rtl/fc_pkg.sv
// ----------------------------------------------------------
// shared definitions for the fully connected engine
// data and address words, memory map, layer sizes,
// fixed-point shift and the phase encoding
// ----------------------------------------------------------
package fc_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 18;

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic        [ADDR_W-1:0] addr_t;
  typedef logic        [8:0]        idx_t;    // buffer entry / counter index

  localparam int FRAC_BITS = 16;              // q16 product scaling

  // external memory map
  localparam int WT_BASE_L1 = 0;
  localparam int BS_BASE_L1 = 48000;
  localparam int WT_BASE_L2 = 50000;
  localparam int BS_BASE_L2 = 51200;
  localparam int IFMAP_BASE = 65536;
  localparam int OFMAP_BASE = 131072;

  // input feature map, stored with x in the low field
  localparam int IFMAP_W = 5;
  localparam int IFMAP_H = 5;
  localparam int IFMAP_D = 16;
  localparam int IFMAP_X_BITS = 5;
  localparam int IFMAP_Y_BITS = 5;
  localparam int IFMAP_Z_BITS = 4;

  localparam int IN_L1 = IFMAP_W * IFMAP_H * IFMAP_D;
  localparam int N_L1  = 120;
  localparam int IN_L2 = N_L1;
  localparam int N_L2  = 10;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LD_IFMAP,
    ST_MAC_L1,     // one weight per cycle
    ST_BIAS_L1,
    ST_MAC_L2,
    ST_BIAS_L2,
    ST_DONE
  } fc_state_t;

endpackage

// File: rtl/fc_ctrl.sv
`timescale 1ns/10ps
// ----------------------------------------------------------
// controller for the fully connected engine
// phase FSM, map load and weight/bias counters,
// read and write address generation, delayed load enables
// ----------------------------------------------------------
module fc_ctrl import fc_pkg::*; (
  input  logic  clk,
  input  logic  srstn,
  input  logic  enable,
  output addr_t addr_in,
  output addr_t addr_out,
  output logic  dram_en_rd,
  output logic  done,
  output logic  ld_ifmap,
  output logic  ld_wt_l1,
  output logic  ld_bs_l1,
  output logic  ld_wt_l2,
  output logic  ld_bs_l2,
  output idx_t  pix_idx_l1,
  output idx_t  pix_idx_l2
);

  fc_state_t state, state_nx;

  logic [IFMAP_X_BITS-1:0] cnt_x;
  logic [IFMAP_Y_BITS-1:0] cnt_y;
  logic [IFMAP_Z_BITS-1:0] cnt_z;
  idx_t cnt_wt1, cnt_bs1;
  idx_t cnt_wt2, cnt_bs2;
  idx_t cnt_bs2_d1, cnt_bs2_d2;

  logic x_last, y_last, z_last, ifmap_last;
  logic wt1_last, bs1_last, wt2_last, bs2_last;

  assign x_last     = (cnt_x == IFMAP_X_BITS'(IFMAP_W - 1));
  assign y_last     = (cnt_y == IFMAP_Y_BITS'(IFMAP_H - 1));
  assign z_last     = (cnt_z == IFMAP_Z_BITS'(IFMAP_D - 1));
  assign ifmap_last = x_last & y_last & z_last;
  assign wt1_last   = (cnt_wt1 == idx_t'(IN_L1 - 1));
  assign bs1_last   = (cnt_bs1 == idx_t'(N_L1 - 1));
  assign wt2_last   = (cnt_wt2 == idx_t'(IN_L2 - 1));
  assign bs2_last   = (cnt_bs2 == idx_t'(N_L2 - 1));

  always_ff @(posedge clk) begin
    if (!srstn) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nx;
    end
  end

  always_comb begin
    case (state)
      ST_IDLE:     state_nx = enable ? ST_LD_IFMAP : ST_IDLE;
      ST_LD_IFMAP: state_nx = ifmap_last ? ST_MAC_L1 : ST_LD_IFMAP;
      ST_MAC_L1:   state_nx = wt1_last ? ST_BIAS_L1 : ST_MAC_L1;
      ST_BIAS_L1:  state_nx = bs1_last ? ST_MAC_L2 : ST_MAC_L1;
      ST_MAC_L2:   state_nx = wt2_last ? ST_BIAS_L2 : ST_MAC_L2;
      ST_BIAS_L2:  state_nx = bs2_last ? ST_DONE : ST_MAC_L2;
      default:     state_nx = ST_IDLE;       // done lasts one cycle
    endcase
  end

  assign done       = (state == ST_DONE);
  assign dram_en_rd = (state != ST_IDLE);

  // map position counters, all wrap back to zero after the last word
  always_ff @(posedge clk) begin
    if (!srstn) begin
      cnt_x <= '0;
      cnt_y <= '0;
      cnt_z <= '0;
    end else if (state == ST_LD_IFMAP) begin
      cnt_x <= x_last ? '0 : cnt_x + 1'b1;
      if (x_last) begin
        cnt_y <= y_last ? '0 : cnt_y + 1'b1;
      end
      if (x_last && y_last) begin
        cnt_z <= z_last ? '0 : cnt_z + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!srstn) begin
      cnt_wt1 <= '0;
      cnt_bs1 <= '0;
      cnt_wt2 <= '0;
      cnt_bs2 <= '0;
    end else begin
      if (state == ST_MAC_L1) begin
        cnt_wt1 <= wt1_last ? '0 : cnt_wt1 + 1'b1;
      end
      if (state == ST_BIAS_L1) begin
        cnt_bs1 <= bs1_last ? '0 : cnt_bs1 + 1'b1;   // neuron index, layer one
      end
      if (state == ST_MAC_L2) begin
        cnt_wt2 <= wt2_last ? '0 : cnt_wt2 + 1'b1;
      end
      if (state == ST_BIAS_L2) begin
        cnt_bs2 <= bs2_last ? '0 : cnt_bs2 + 1'b1;
      end
    end
  end

  always_comb begin
    case (state)
      ST_LD_IFMAP: addr_in = addr_t'(IFMAP_BASE) + addr_t'({cnt_z, cnt_y, cnt_x});
      ST_MAC_L1:   addr_in = addr_t'(WT_BASE_L1) + addr_t'(cnt_bs1) * addr_t'(IN_L1)
                             + addr_t'(cnt_wt1);
      ST_BIAS_L1:  addr_in = addr_t'(BS_BASE_L1) + addr_t'(cnt_bs1);
      ST_MAC_L2:   addr_in = addr_t'(WT_BASE_L2) + addr_t'(cnt_bs2) * addr_t'(IN_L2)
                             + addr_t'(cnt_wt2);
      ST_BIAS_L2:  addr_in = addr_t'(BS_BASE_L2) + addr_t'(cnt_bs2);
      default:     addr_in = '0;
    endcase
  end

  // memory answers one cycle after the address, so loads trail the phase
  always_ff @(posedge clk) begin
    if (!srstn) begin
      ld_ifmap   <= 1'b0;
      ld_wt_l1   <= 1'b0;
      ld_bs_l1   <= 1'b0;
      ld_wt_l2   <= 1'b0;
      ld_bs_l2   <= 1'b0;
      pix_idx_l1 <= '0;
      pix_idx_l2 <= '0;
      cnt_bs2_d1 <= '0;
      cnt_bs2_d2 <= '0;
    end else begin
      ld_ifmap   <= (state == ST_LD_IFMAP);
      ld_wt_l1   <= (state == ST_MAC_L1);
      ld_bs_l1   <= (state == ST_BIAS_L1);
      ld_wt_l2   <= (state == ST_MAC_L2);
      ld_bs_l2   <= (state == ST_BIAS_L2);
      pix_idx_l1 <= cnt_wt1;
      pix_idx_l2 <= cnt_wt2;
      cnt_bs2_d1 <= cnt_bs2;
      cnt_bs2_d2 <= cnt_bs2_d1;   // lines up with the layer-two result
    end
  end

  assign addr_out = addr_t'(OFMAP_BASE) + addr_t'(cnt_bs2_d2);

endmodule

// File: rtl/fc_shift_buf.sv
`timescale 1ns/10ps
// ----------------------------------------------------------
// shift-in feature buffer
// newest word enters the top slot, one registered read port
// ----------------------------------------------------------
module fc_shift_buf import fc_pkg::*; #(
  parameter int DEPTH = 400
) (
  input  logic  clk,
  input  logic  srstn,
  input  logic  shift_en,
  input  data_t din,
  input  idx_t  rd_idx,
  output data_t dout
);

  data_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (shift_en) begin
      mem[DEPTH-1] <= din;
      for (int k = 0; k < DEPTH - 1; k++) begin
        mem[k] <= mem[k+1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!srstn) begin
      dout <= '0;
    end else begin
      dout <= mem[rd_idx[$clog2(DEPTH)-1:0]];
    end
  end

endmodule

// File: rtl/fc_mac_unit.sv
`timescale 1ns/10ps
// ----------------------------------------------------------
// neuron unit for one layer
// weight/bias capture, q16 multiply-accumulate,
// bias add and relu on the finished sum
// ----------------------------------------------------------
module fc_mac_unit import fc_pkg::*; (
  input  logic  clk,
  input  logic  srstn,
  input  logic  ld_wt,
  input  logic  ld_bs,
  input  data_t data_in,
  input  data_t pixel,
  output data_t result,
  output logic  result_valid
);

  data_t wt;
  data_t bs;
  data_t acc;
  data_t prod;
  data_t prod_sh;
  data_t acc_bs;
  logic  prod_valid;
  logic  bs_valid;

  always_ff @(posedge clk) begin
    if (ld_wt) begin
      wt <= data_in;
    end
    if (ld_bs) begin
      bs <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (!srstn) begin
      prod_valid <= 1'b0;
      bs_valid   <= 1'b0;
    end else begin
      prod_valid <= ld_wt;   // weight and pixel line up one cycle later
      bs_valid   <= ld_bs;
    end
  end

  assign prod    = wt * pixel;             // low 32 bits only
  assign prod_sh = prod >>> FRAC_BITS;

  always_ff @(posedge clk) begin
    if (!srstn) begin
      acc <= '0;
    end else if (bs_valid) begin
      acc <= '0;                           // sum consumed, next neuron
    end else if (prod_valid) begin
      acc <= acc + prod_sh;
    end
  end

  assign acc_bs       = acc + bs;
  assign result       = acc_bs[DATA_W-1] ? '0 : acc_bs;
  assign result_valid = bs_valid;

endmodule

// File: rtl/fc_top.sv
`timescale 1ns/10ps
// ----------------------------------------------------------
// fully connected inference engine, top level
// controller, input map and layer-one result buffers,
// one neuron unit per layer
// ----------------------------------------------------------
module fc_top import fc_pkg::*; (
  input  logic  clk,
  input  logic  srstn,
  input  logic  enable,
  input  logic  dram_valid,      // kept for pin compatibility
  input  data_t data_in,
  output data_t data_out,
  output addr_t addr_in,
  output addr_t addr_out,
  output logic  dram_en_wr,
  output logic  dram_en_rd,
  output logic  done
);

  logic  ld_ifmap;
  logic  ld_wt_l1;
  logic  ld_bs_l1;
  logic  ld_wt_l2;
  logic  ld_bs_l2;
  idx_t  pix_idx_l1;
  idx_t  pix_idx_l2;
  data_t pixel_l1;
  data_t pixel_l2;
  data_t result_l1;
  logic  result_valid_l1;

  fc_ctrl i_ctrl (
    .clk        (clk),
    .srstn      (srstn),
    .enable     (enable),
    .addr_in    (addr_in),
    .addr_out   (addr_out),
    .dram_en_rd (dram_en_rd),
    .done       (done),
    .ld_ifmap   (ld_ifmap),
    .ld_wt_l1   (ld_wt_l1),
    .ld_bs_l1   (ld_bs_l1),
    .ld_wt_l2   (ld_wt_l2),
    .ld_bs_l2   (ld_bs_l2),
    .pix_idx_l1 (pix_idx_l1),
    .pix_idx_l2 (pix_idx_l2)
  );

  fc_shift_buf #(.DEPTH(IN_L1)) i_ifmap_buf (
    .clk      (clk),
    .srstn    (srstn),
    .shift_en (ld_ifmap),
    .din      (data_in),
    .rd_idx   (pix_idx_l1),
    .dout     (pixel_l1)
  );

  fc_mac_unit i_mac_l1 (
    .clk          (clk),
    .srstn        (srstn),
    .ld_wt        (ld_wt_l1),
    .ld_bs        (ld_bs_l1),
    .data_in      (data_in),
    .pixel        (pixel_l1),
    .result       (result_l1),
    .result_valid (result_valid_l1)
  );

  // layer-one outputs become the layer-two input vector
  fc_shift_buf #(.DEPTH(N_L1)) i_l1_buf (
    .clk      (clk),
    .srstn    (srstn),
    .shift_en (result_valid_l1),
    .din      (result_l1),
    .rd_idx   (pix_idx_l2),
    .dout     (pixel_l2)
  );

  fc_mac_unit i_mac_l2 (
    .clk          (clk),
    .srstn        (srstn),
    .ld_wt        (ld_wt_l2),
    .ld_bs        (ld_bs_l2),
    .data_in      (data_in),
    .pixel        (pixel_l2),
    .result       (data_out),
    .result_valid (dram_en_wr)   // each layer-two result is written straight out
  );

endmodule

// File: tb/fc_dram_model.sv
`timescale 1ns/10ps
// ----------------------------------------------------------
// external memory model for the testbench
// sparse word store, one-cycle read latency,
// write log with addresses, read-cycle count
// ----------------------------------------------------------
module fc_dram_model import fc_pkg::*; (
  input  logic  clk,
  input  logic  en_rd,
  input  addr_t addr_rd,
  output data_t rdata,
  input  logic  en_wr,
  input  addr_t addr_wr,
  input  data_t wdata
);

  data_t       mem [addr_t];
  addr_t       wr_addr_q [$];
  int unsigned n_reads;

  function automatic data_t lookup(input addr_t a);
    return mem.exists(a) ? mem[a] : '0;   // unwritten words read as zero
  endfunction

  task automatic store(input addr_t a, input data_t d);
    mem[a] = d;
  endtask

  initial begin
    rdata   = '0;
    n_reads = 0;
  end

  // the read port answers every cycle, en_rd only feeds the count
  always @(posedge clk) begin
    rdata <= lookup(addr_rd);
    if (en_rd) begin
      n_reads++;
    end
    if (en_wr) begin
      mem[addr_wr] = wdata;
      wr_addr_q.push_back(addr_wr);
    end
  end

endmodule

// File: tb/fc_tb.sv
`timescale 1ns/10ps
// ----------------------------------------------------------
// testbench for the fully connected engine
// clock, reset, memory fill, reference model,
// read schedule walk and write compare process
// ----------------------------------------------------------
module fc_tb import fc_pkg::*; ();

  localparam int unsigned SEED       = 32'h0c1e_d7f3;
  localparam int          RUN_CYCLES = IN_L1 + N_L1 * (IN_L1 + 1) + N_L2 * (IN_L2 + 1) + 1;
  localparam int          MAX_CYCLES = 120000;   // two runs plus margin

  logic  clk = 1'b0;
  logic  srstn;
  logic  enable;
  logic  dram_valid;
  data_t data_in;
  data_t data_out;
  addr_t addr_in;
  addr_t addr_out;
  logic  dram_en_wr;
  logic  dram_en_rd;
  logic  done;

  int          wt1 [N_L1*IN_L1];
  int          bs1 [N_L1];
  int          wt2 [N_L2*IN_L2];
  int          bs2 [N_L2];
  int          pix [IN_L1];
  int          exp_out [N_L2];
  int          wr_idx;
  bit          expect_zero;
  int unsigned cycle = 0;
  int unsigned en_cycle;
  int          n_val_err = 0;
  int          n_other_err = 0;

  fc_top i_dut (
    .clk        (clk),
    .srstn      (srstn),
    .enable     (enable),
    .dram_valid (dram_valid),
    .data_in    (data_in),
    .data_out   (data_out),
    .addr_in    (addr_in),
    .addr_out   (addr_out),
    .dram_en_wr (dram_en_wr),
    .dram_en_rd (dram_en_rd),
    .done       (done)
  );

  fc_dram_model i_mem (
    .clk     (clk),
    .en_rd   (dram_en_rd),
    .addr_rd (addr_in),
    .rdata   (data_in),
    .en_wr   (dram_en_wr),
    .addr_wr (addr_out),
    .wdata   (data_out)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic int rand_signed(input int mag);
    return int'($urandom_range(2 * mag - 1)) - mag;
  endfunction

  // x in the low field, then y, then z
  function automatic addr_t ifmap_addr(input int n);
    int x;
    int y;
    int z;
    x = n % IFMAP_W;
    y = (n / IFMAP_W) % IFMAP_H;
    z = n / (IFMAP_W * IFMAP_H);
    return addr_t'(IFMAP_BASE + (z << (IFMAP_X_BITS + IFMAP_Y_BITS)) + (y << IFMAP_X_BITS) + x);
  endfunction

  task automatic fill_memory(input bit neg_bias);
    for (int a = 0; a < N_L1 * IN_L1; a++) begin
      wt1[a] = rand_signed(4096);
      i_mem.store(addr_t'(WT_BASE_L1 + a), data_t'(wt1[a]));
    end
    for (int k = 0; k < N_L1; k++) begin
      bs1[k] = rand_signed(65536);
      i_mem.store(addr_t'(BS_BASE_L1 + k), data_t'(bs1[k]));
    end
    for (int a = 0; a < N_L2 * IN_L2; a++) begin
      wt2[a] = rand_signed(256);
    end
    wt2[0] = 0;   // slot 0 of the result buffer is read on the edge of the last shift
    for (int a = 0; a < N_L2 * IN_L2; a++) begin
      i_mem.store(addr_t'(WT_BASE_L2 + a), data_t'(wt2[a]));
    end
    for (int j = 0; j < N_L2; j++) begin
      bs2[j] = neg_bias ? -(1 << 28) + rand_signed(4096) : rand_signed(65536);
      i_mem.store(addr_t'(BS_BASE_L2 + j), data_t'(bs2[j]));
    end
    for (int n = 0; n < IN_L1; n++) begin
      pix[n] = rand_signed(65536);
      i_mem.store(ifmap_addr(n), data_t'(pix[n]));
    end
  endtask

  // products keep the low 32 bits, sums wrap, negative results clamp to 0
  function automatic void fc_ref();
    int acc;
    int prod;
    int l1_out [N_L1];
    for (int k = 0; k < N_L1; k++) begin
      acc = 0;
      for (int w = 0; w < IN_L1; w++) begin
        prod = wt1[k*IN_L1 + w] * pix[w];
        acc  = acc + (prod >>> FRAC_BITS);
      end
      acc = acc + bs1[k];
      l1_out[k] = (acc < 0) ? 0 : acc;
    end
    for (int j = 0; j < N_L2; j++) begin
      acc = 0;
      for (int i = 0; i < IN_L2; i++) begin
        prod = wt2[j*IN_L2 + i] * l1_out[i];
        acc  = acc + (prod >>> FRAC_BITS);
      end
      acc = acc + bs2[j];
      exp_out[j] = (acc < 0) ? 0 : acc;
    end
  endfunction

  task automatic check_idle(input int n);
    repeat (n) begin
      @(negedge clk);
      assert (!dram_en_rd && !dram_en_wr && !done) else begin
        n_other_err++;
        $display("engine left idle without enable at time %0t", $time);
      end
    end
  endtask

  task automatic expect_read(input addr_t a);
    @(negedge clk);
    assert (addr_in == a) else begin
      n_val_err++;
      $display("[ERROR] %0t read address %0d, expected %0d", $time, addr_in, a);
    end
    assert (dram_en_rd && !done) else begin
      n_other_err++;
      $display("read enable low or done high inside the read schedule at time %0t", $time);
    end
  endtask

  task automatic walk_schedule();
    for (int n = 0; n < IN_L1; n++) begin
      expect_read(ifmap_addr(n));
    end
    for (int k = 0; k < N_L1; k++) begin
      for (int w = 0; w < IN_L1; w++) begin
        expect_read(addr_t'(WT_BASE_L1 + k * IN_L1 + w));
      end
      expect_read(addr_t'(BS_BASE_L1 + k));
    end
    for (int j = 0; j < N_L2; j++) begin
      for (int i = 0; i < IN_L2; i++) begin
        expect_read(addr_t'(WT_BASE_L2 + j * IN_L2 + i));
      end
      expect_read(addr_t'(BS_BASE_L2 + j));
    end
    @(negedge clk);
    assert (done && dram_en_rd && (cycle - en_cycle == RUN_CYCLES)) else begin
      n_other_err++;
      $display("done pulse missing %0d cycles after enable, time %0t", RUN_CYCLES, $time);
    end
    @(negedge clk);
    assert (!done && !dram_en_rd && dram_en_wr) else begin
      n_other_err++;
      $display("done too long, read enable still high or last write late at %0t", $time);
    end
    @(negedge clk);
    assert (!dram_en_wr) else begin
      n_other_err++;
      $display("write strobe still high after the last result at time %0t", $time);
    end
  endtask

  task automatic run_inference(input bit neg_bias);
    int n_wr_before;
    int unsigned n_rd_before;
    fill_memory(neg_bias);
    fc_ref();
    wr_idx      = 0;
    expect_zero = neg_bias;
    n_wr_before = i_mem.wr_addr_q.size();
    n_rd_before = i_mem.n_reads;
    @(posedge clk);
    enable   <= 1'b1;
    en_cycle = cycle + 1;   // counter value once this edge has passed
    @(posedge clk);
    enable <= 1'b0;
    walk_schedule();
    assert ((wr_idx == N_L2) && (i_mem.wr_addr_q.size() - n_wr_before == N_L2)) else begin
      n_other_err++;
      $display("expected %0d result writes, the engine made %0d", N_L2, wr_idx);
    end
    assert (i_mem.n_reads - n_rd_before == RUN_CYCLES) else begin
      n_other_err++;
      $display("read enable was high for %0d cycles instead of %0d",
               i_mem.n_reads - n_rd_before, RUN_CYCLES);
    end
  endtask

  // compare process for the result writes
  always @(negedge clk) begin
    if (srstn && dram_en_wr) begin
      if (wr_idx < N_L2) begin
        assert (addr_out == addr_t'(OFMAP_BASE + wr_idx)) else begin
          n_val_err++;
          $display("[ERROR] %0t write %0d to address %0d, expected %0d", $time, wr_idx,
                   addr_out, addr_t'(OFMAP_BASE + wr_idx));
        end
        assert (data_out == data_t'(exp_out[wr_idx])) else begin
          n_val_err++;
          $display("[ERROR] %0t output %0d is %0d, expected %0d", $time, wr_idx,
                   data_out, exp_out[wr_idx]);
        end
        if (expect_zero) begin
          assert (data_out == '0) else begin
            n_val_err++;
            $display("[ERROR] %0t output %0d is %0d under negative bias, expected 0",
                     $time, wr_idx, data_out);
          end
        end
      end else begin
        n_other_err++;
        $display("extra result write beyond the last neuron at time %0t", $time);
      end
      wr_idx++;
    end
  end

  initial begin
    void'($urandom(SEED));
    srstn      = 1'b0;
    enable     = 1'b0;
    dram_valid = 1'b1;
    repeat (10) @(posedge clk);
    srstn <= 1'b1;
    check_idle(20);
    run_inference(1'b0);
    run_inference(1'b1);   // second run, every layer-two bias far below zero
    repeat (5) @(posedge clk);
    $display("errors: %0d wrong values, %0d other failures", n_val_err, n_other_err);
    if (n_val_err + n_other_err == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
rtl/fc_pkg.sv
rtl/fc_ctrl.sv
rtl/fc_shift_buf.sv
rtl/fc_mac_unit.sv
rtl/fc_top.sv
tb/fc_dram_model.sv
tb/fc_tb.sv

// File: Makefile
# Verilator build for the fully connected engine

VERILATOR  ?= verilator
FLIST      ?= compile.f
TOP        ?= fc_tb
RTL_TOP    ?= fc_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall -Wno-fatal
SIM_FLAGS  ?= --timing --assert -Wno-fatal

SRCS     := $(shell grep -v '^+' $(FLIST))
RTL_SRCS := $(shell grep '^rtl/' $(FLIST))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
	  echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TEST OK" $(LOG); then \
	  echo "simulation ended without a result line"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
